// File: Makefile
VERILATOR ?= verilator
TOP       ?= frontend_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

// File: bpu/bpu.sv
`default_nettype none

module bpu (
    input  logic                       clk,
    input  logic                       reset,
    input  frontend_pkg::fetch_resp_t  fetch_resp,
    input  logic                       epoch,
    input  frontend_pkg::update_info_t update_info,
    output logic                       push,
    output frontend_pkg::inst_and_pc_t push_entry,
    output logic                       pre_redirect,
    output logic [31:0]                pre_branch_addr
);

    import frontend_pkg::*;

    logic [5:0]  opcode;
    logic        is_uncond;
    logic        is_cond;
    logic        is_jirl;
    logic        bht_taken;
    logic        pre_taken;
    logic [31:0] offset;
    logic [31:0] target;

    ////////////////////
    // Pre-decode
    ////////////////////

    assign opcode = fetch_resp.inst.i26.opcode;

    always_comb begin
        is_uncond = 1'b0;
        is_cond   = 1'b0;
        is_jirl   = 1'b0;
        case (opcode)
            op_b, op_bl: is_uncond = 1'b1;
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: is_cond = 1'b1;
            op_jirl: is_jirl = 1'b1;
            default: ;
        endcase
    end

    // Byte offset sign extended from the view the opcode selects
    assign offset = is_uncond
        ? {{4{fetch_resp.inst.i26.offs_hi[9]}}, fetch_resp.inst.i26.offs_hi,
           fetch_resp.inst.i26.offs_lo, 2'b00}
        : {{14{fetch_resp.inst.i16.offs[15]}}, fetch_resp.inst.i16.offs, 2'b00};

    assign target = fetch_resp.pc + offset;

    ////////////////////
    // Direction
    ////////////////////

    branch_history_table u_branch_history_table (
        .clk,
        .reset,
        .rd_pc    (fetch_resp.pc),
        .wr_en    (update_info.valid & update_info.is_cond),
        .wr_pc    (update_info.pc),
        .wr_taken (update_info.taken),
        .rd_taken (bht_taken)
    );

    // JIRL never predicted taken
    assign pre_taken = is_uncond | (is_cond & bht_taken);

    // Responses from an older epoch belong to a dropped path
    assign push = fetch_resp.valid & (fetch_resp.epoch == epoch);

    assign pre_redirect    = push & pre_taken;
    assign pre_branch_addr = target;

    assign push_entry.inst                   = fetch_resp.inst;
    assign push_entry.pc                     = fetch_resp.pc;
    assign push_entry.branch_info.is_branch  = is_uncond | is_cond | is_jirl;
    assign push_entry.branch_info.pre_taken  = pre_taken;
    assign push_entry.branch_info.pre_target = target;

endmodule

`default_nettype wire

// File: bpu/branch_history_table.sv
`default_nettype none

module branch_history_table (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] rd_pc,
    input  logic        wr_en,
    input  logic [31:0] wr_pc,
    input  logic        wr_taken,
    output logic        rd_taken
);

    import frontend_pkg::*;

    logic [1:0]                counters [0:(1 << bht_index_bits) - 1];
    logic [bht_index_bits-1:0] rd_idx;
    logic [bht_index_bits-1:0] wr_idx;

    // Word-aligned PCs, so skip the two low bits
    assign rd_idx = rd_pc[bht_index_bits+1:2];
    assign wr_idx = wr_pc[bht_index_bits+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << bht_index_bits); i++) begin
                counters[i] <= 2'b01;
            end
        end else if (wr_en) begin
            // Saturate at 00 and 11
            if (wr_taken && counters[wr_idx] != 2'b11) begin
                counters[wr_idx] <= counters[wr_idx] + 2'd1;
            end else if (!wr_taken && counters[wr_idx] != 2'b00) begin
                counters[wr_idx] <= counters[wr_idx] - 2'd1;
            end
        end
    end

    assign rd_taken = counters[rd_idx][1];

endmodule

`default_nettype wire

// File: common/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    ////////////////////
    // Sizes and reset values
    ////////////////////

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // 64 counters indexed by pc[7:2]
    localparam int bht_index_bits = 6;

    localparam int ibuf_depth    = 8;
    localparam int ibuf_ptr_bits = 3;

    ////////////////////
    // Opcodes in the top six bits of the word
    ////////////////////

    localparam logic [5:0] op_jirl = 6'b010011;
    localparam logic [5:0] op_b    = 6'b010100;
    localparam logic [5:0] op_bl   = 6'b010101;
    localparam logic [5:0] op_beq  = 6'b010110;
    localparam logic [5:0] op_bne  = 6'b010111;
    localparam logic [5:0] op_blt  = 6'b011000;
    localparam logic [5:0] op_bge  = 6'b011001;
    localparam logic [5:0] op_bltu = 6'b011010;
    localparam logic [5:0] op_bgeu = 6'b011011;

    ////////////////////
    // Instruction word views
    ////////////////////

    // B and BL with the 26-bit offset split in two
    typedef struct packed {
        logic [5:0]  opcode;
        logic [9:0]  offs_hi;
        logic [15:0] offs_lo;
    } inst_i26_t;

    // Conditional branches and JIRL
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_i16_t;

    typedef union packed {
        inst_i26_t i26;
        inst_i16_t i16;
    } inst_word_u;

    ////////////////////
    // Port records
    ////////////////////

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        epoch;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_word_u  inst;
        logic        epoch;
    } fetch_resp_t;

    typedef struct packed {
        logic        is_branch;
        logic        pre_taken;
        logic [31:0] pre_target;
    } branch_info_t;

    typedef struct packed {
        logic [31:0]  inst;
        logic [31:0]  pc;
        branch_info_t branch_info;
    } inst_and_pc_t;

    // One record per resolved branch from the backend
    typedef struct packed {
        logic        valid;
        logic        is_cond;
        logic        branch_flush;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] branch_actual_addr;
    } update_info_t;

endpackage

`default_nettype wire

// File: dv/frontend_tb.sv
`default_nettype none

module frontend_tb;

    import frontend_pkg::*;

    localparam int num_deliver = 80;
    localparam int wait_limit  = 3000;

    // One accepted fetch waiting in the cache model
    typedef struct packed {
        logic [31:0] pc;
        logic        epoch;
        logic [31:0] due;
    } pending_t;

    logic         clk;
    logic         reset;
    logic         icache_stall;
    logic         send_inst_en;
    logic         inst_out_valid;
    fetch_resp_t  fetch_resp;
    update_info_t update_info;
    fetch_req_t   fetch_req;
    inst_and_pc_t inst_out;

    int          seed      = 44706;
    int          errors    = 0;
    int          delivered = 0;
    int          beq_seen  = 0;
    int          timeout   = 0;
    logic        jirl_seen = 1'b0;
    logic [31:0] cycle     = '0;
    logic [31:0] last_due  = '0;
    logic [31:0] exp_pc;
    logic [1:0]  beq_ctr;
    pending_t    pending [$];

    frontend_top i_frontend_top (
        .clk,
        .reset,
        .icache_stall,
        .fetch_resp,
        .update_info,
        .send_inst_en,
        .fetch_req,
        .inst_out,
        .inst_out_valid
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    ////////////////////
    // Instruction memory
    ////////////////////

    // B at word 4, BEQ at word 20 (loop back to 8), JIRL at word 30 (to word 40)
    function automatic logic [31:0] mem_word(input logic [31:0] pc);
        logic [31:0] idx;
        idx = (pc - reset_pc) >> 2;
        case (idx)
            32'd4:   return {op_b, 10'd0, 16'd12};
            32'd20:  return {op_beq, 16'hfff4, 5'd1, 5'd2};
            32'd30:  return {op_jirl, 16'd0, 5'd1, 5'd0};
            default: return {6'b000000, pc[27:2] ^ {pc[31:28], pc[1:0], 20'd0}};
        endcase
    endfunction

    ////////////////////
    // Cache model
    ////////////////////

    always @(posedge clk) begin
        pending_t    req;
        fetch_resp_t resp;
        logic [31:0] delay;
        resp = '0;
        if (reset) begin
            pending.delete();
            fetch_resp   <= '0;
            icache_stall <= 1'b0;
            last_due = '0;
        end else begin
            if (fetch_req.valid && !icache_stall) begin
                // One or two cycles of latency with responses kept in order
                delay     = 32'($random(seed) & 1);
                req.pc    = fetch_req.pc;
                req.epoch = fetch_req.epoch;
                req.due   = cycle + delay;
                if (req.due <= last_due) begin
                    req.due = last_due + 32'd1;
                end
                last_due = req.due;
                pending.push_back(req);
            end
            if (pending.size() > 0 && pending[0].due <= cycle) begin
                req        = pending.pop_front();
                resp.valid = 1'b1;
                resp.pc    = req.pc;
                resp.inst  = mem_word(req.pc);
                resp.epoch = req.epoch;
            end
            fetch_resp   <= resp;
            icache_stall <= ($random(seed) % 5) == 0;
        end
        cycle = cycle + 32'd1;
    end

    ////////////////////
    // Backend model
    ////////////////////

    always @(posedge clk) begin
        inst_and_pc_t e;
        update_info_t upd;
        logic         act_taken;
        logic [31:0]  act_next;
        logic         exp_branch;
        logic         exp_taken;
        logic [31:0]  exp_target;
        upd = '0;
        if (reset) begin
            send_inst_en <= 1'b0;
            update_info  <= '0;
            exp_pc  = reset_pc;
            beq_ctr = 2'b01;
        end else begin
            // A transfer in the flush cycle is discarded by the buffer
            if (inst_out_valid && send_inst_en
                && !(update_info.valid && update_info.branch_flush)) begin
                e          = inst_out;
                exp_branch = 1'b0;
                exp_taken  = 1'b0;
                exp_target = e.pc;
                act_taken  = 1'b0;
                act_next   = e.pc + 32'd4;
                case (e.inst[31:26])
                    op_b: begin
                        exp_branch = 1'b1;
                        exp_taken  = 1'b1;
                        exp_target = e.pc + 32'd48;
                        act_taken  = 1'b1;
                        act_next   = e.pc + 32'd48;
                    end
                    op_beq: begin
                        exp_branch = 1'b1;
                        exp_taken  = beq_ctr[1];
                        exp_target = e.pc - 32'd48;
                        // Loop three times, then fall through
                        act_taken  = beq_seen < 3;
                        if (act_taken) begin
                            act_next = e.pc - 32'd48;
                        end
                    end
                    op_jirl: begin
                        exp_branch = 1'b1;
                        act_taken  = 1'b1;
                        act_next   = reset_pc + 32'd160;
                    end
                    default: ;
                endcase
                assert (e.pc == exp_pc)
                    else report_fail($sformatf("pc %h, expected %h", e.pc, exp_pc));
                assert (e.inst == mem_word(e.pc))
                    else report_fail($sformatf("wrong word at pc %h", e.pc));
                assert (e.branch_info.is_branch == exp_branch
                        && e.branch_info.pre_taken == exp_taken)
                    else report_fail($sformatf("wrong prediction at pc %h", e.pc));
                if (exp_taken) begin
                    assert (e.branch_info.pre_target == exp_target)
                        else report_fail($sformatf("wrong target at pc %h", e.pc));
                end
                if (exp_branch) begin
                    upd.valid              = 1'b1;
                    upd.is_cond            = e.inst[31:26] == op_beq;
                    upd.branch_flush       = exp_taken != act_taken;
                    upd.pc                 = e.pc;
                    upd.taken              = act_taken;
                    upd.branch_actual_addr = act_next;
                end
                if (e.inst[31:26] == op_beq) begin
                    beq_seen++;
                    if (act_taken && beq_ctr != 2'b11) begin
                        beq_ctr = beq_ctr + 2'd1;
                    end else if (!act_taken && beq_ctr != 2'b00) begin
                        beq_ctr = beq_ctr - 2'd1;
                    end
                end
                if (e.inst[31:26] == op_jirl) begin
                    jirl_seen = 1'b1;
                end
                exp_pc = act_next;
                delivered++;
            end
            update_info  <= upd;
            send_inst_en <= ($random(seed) % 3) != 0;
        end
    end

    // Held output must not move
    assert property (@(posedge clk) disable iff (reset)
        (inst_out_valid && !send_inst_en && !(update_info.valid && update_info.branch_flush))
        |=> (inst_out_valid && $stable(inst_out)))
        else report_fail("inst_out changed while held");

    initial begin
        reset        = 1'b1;
        icache_stall = 1'b0;
        send_inst_en = 1'b0;
        fetch_resp   = '0;
        update_info  = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        #1;
        assert (fetch_req.valid && fetch_req.pc == reset_pc && !fetch_req.epoch
                && !inst_out_valid)
            else report_fail("wrong state after reset");

        while (delivered < num_deliver && timeout < wait_limit) begin
            @(posedge clk);
            timeout++;
        end
        if (timeout >= wait_limit) begin
            errors++;
            $display("Timed out waiting for instructions, %0d delivered", delivered);
        end
        assert (beq_seen == 4 && jirl_seen)
            else report_fail("branch path not fully covered");

        $display("Errors: %0d, instructions delivered: %0d", errors, delivered);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/frontend_top.sv
`default_nettype none

module frontend_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       icache_stall,
    input  frontend_pkg::fetch_resp_t  fetch_resp,
    input  frontend_pkg::update_info_t update_info,
    input  logic                       send_inst_en,
    output frontend_pkg::fetch_req_t   fetch_req,
    output frontend_pkg::inst_and_pc_t inst_out,
    output logic                       inst_out_valid
);

    import frontend_pkg::*;

    logic         epoch;
    logic         pre_redirect;
    logic [31:0]  pre_branch_addr;
    logic         push;
    inst_and_pc_t push_entry;
    logic         ibuf_almost_full;

    pc_reg u_pc_reg (
        .clk,
        .reset,
        .icache_stall,
        .ibuf_almost_full,
        .pre_redirect,
        .pre_branch_addr,
        .update_info,
        .fetch_req,
        .epoch
    );

    bpu u_bpu (
        .clk,
        .reset,
        .fetch_resp,
        .epoch,
        .update_info,
        .push,
        .push_entry,
        .pre_redirect,
        .pre_branch_addr
    );

    // Only a valid update with a misprediction flushes the queue
    instbuffer u_instbuffer (
        .clk,
        .reset,
        .push,
        .push_entry,
        .branch_flush     (update_info.valid & update_info.branch_flush),
        .send_inst_en,
        .inst_out,
        .inst_out_valid,
        .ibuf_almost_full
    );

endmodule

`default_nettype wire

// File: source/instbuffer.sv
`default_nettype none

module instbuffer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  frontend_pkg::inst_and_pc_t push_entry,
    input  logic                       branch_flush,
    input  logic                       send_inst_en,
    output frontend_pkg::inst_and_pc_t inst_out,
    output logic                       inst_out_valid,
    output logic                       ibuf_almost_full
);

    import frontend_pkg::*;

    inst_and_pc_t             entries [0:ibuf_depth-1];
    logic [ibuf_ptr_bits-1:0] rd_ptr;
    logic [ibuf_ptr_bits-1:0] wr_ptr;
    logic [ibuf_ptr_bits:0]   count;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign full    = count == (ibuf_ptr_bits + 1)'(ibuf_depth);
    assign do_pop  = inst_out_valid & send_inst_en;
    // A pop in the same cycle frees the slot for a push
    assign do_push = push & (~full | do_pop);

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset || branch_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (do_push && !branch_flush) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    assign inst_out       = entries[rd_ptr];
    assign inst_out_valid = count != '0;

    // Two or fewer free slots left
    assign ibuf_almost_full = count >= (ibuf_ptr_bits + 1)'(ibuf_depth - 2);

endmodule

`default_nettype wire

// File: source/pc_reg.sv
`default_nettype none

module pc_reg (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       icache_stall,
    input  logic                       ibuf_almost_full,
    input  logic                       pre_redirect,
    input  logic [31:0]                pre_branch_addr,
    input  frontend_pkg::update_info_t update_info,
    output frontend_pkg::fetch_req_t   fetch_req,
    output logic                       epoch
);

    import frontend_pkg::*;

    logic [31:0] pc;
    logic        backend_flush;
    logic        req_accepted;

    assign backend_flush = update_info.valid & update_info.branch_flush;
    assign req_accepted  = fetch_req.valid & ~icache_stall;

    // Backend flush beats a predicted redirect; both flip the epoch
    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= reset_pc;
            epoch <= 1'b0;
        end else if (backend_flush) begin
            pc    <= update_info.branch_actual_addr;
            epoch <= ~epoch;
        end else if (pre_redirect) begin
            pc    <= pre_branch_addr;
            epoch <= ~epoch;
        end else if (req_accepted) begin
            pc <= pc + 32'd4;
        end
    end

    // Stop issuing while the buffer may not hold what is in flight
    assign fetch_req.valid = ~ibuf_almost_full;
    assign fetch_req.pc    = pc;
    assign fetch_req.epoch = epoch;

endmodule

`default_nettype wire

// File: verilog.f
common/frontend_pkg.sv
bpu/branch_history_table.sv
bpu/bpu.sv
source/pc_reg.sv
source/instbuffer.sv
source/frontend_top.sv
dv/frontend_tb.sv
